// ==== Makefile ====
# Verilator build and run for the DDR2 address/command path testbench

VERILATOR ?= verilator
TOP ?= tb_ddr2_addr_cmd
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
verilog/ddr2_cmd_pkg.sv
verilog/cmd_queue.sv
verilog/half_rate_cmd_packer.sv
verilog/addr_cmd_datapath.sv
verilog/ddio_cmd_out.sv
verilog/ddr2_addr_cmd_top.sv
verification/addr_cmd_assertions.sv
verification/tb_ddr2_addr_cmd.sv

// ==== verification/addr_cmd_assertions.sv ====
// command queue protocol assertions
// checks push against fullness, pop against occupancy and the credit range
`timescale 1ns/1ps

module addr_cmd_assertions import ddr2_cmd_pkg::*; (
	input logic         clk,
	input logic         reset_n,
	input logic         cmd_valid,
	input credit_t      pop,
	input queue_count_t occupancy,
	input credit_t      cmd_credit
);

	// the client only pushes while it holds a credit
	no_push_when_full: assert property (@(posedge clk) disable iff (!reset_n)
		cmd_valid |-> (occupancy < queue_count_t'(QUEUE_DEPTH)))
		else $error("push into a full command queue");

	pop_within_occupancy: assert property (@(posedge clk) disable iff (!reset_n)
		queue_count_t'(pop) <= occupancy)
		else $error("pop count exceeds queue occupancy");

	credit_at_most_two: assert property (@(posedge clk) disable iff (!reset_n)
		cmd_credit <= credit_t'(2))
		else $error("credit return above two entries");

	occupancy_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		occupancy <= queue_count_t'(QUEUE_DEPTH))
		else $error("queue occupancy above its depth");

endmodule

bind cmd_queue addr_cmd_assertions addr_cmd_assertions_inst (
	.clk(clk),
	.reset_n(reset_n),
	.cmd_valid(cmd_valid),
	.pop(pop),
	.occupancy(occupancy),
	.cmd_credit(cmd_credit)
);

// ==== verification/tb_ddr2_addr_cmd.sv ====
// testbench for the DDR2 half-rate address/command path
// random credit-limited commands checked in order against the memory pin stream
`timescale 1ns/1ps

module tb_ddr2_addr_cmd import ddr2_cmd_pkg::*; ();

	localparam int DRAIN_TIMEOUT = 200;

	logic      clk;
	logic      reset_n;
	logic      cmd_valid;
	mem_addr_t cmd_addr;
	mem_bank_t cmd_bank;
	logic      cmd_cs_n, cmd_ras_n, cmd_cas_n, cmd_we_n, cmd_cke, cmd_odt;
	credit_t   cmd_credit;
	mem_addr_t mem_addr;
	mem_bank_t mem_bank;
	logic      mem_cs_n, mem_ras_n, mem_cas_n, mem_we_n, mem_cke, mem_odt;

	// expected commands in push order, {addr, bank, cs_n, ras_n, cas_n, we_n, cke, odt}
	cmd_entry_t exp_queue[$];
	int         seed = 76761;
	int         credits;
	int         credit_total;
	int         seen_count;
	logic       last_cke;
	logic       last_odt;

	ddr2_addr_cmd_top ddr2_addr_cmd_top_inst (
		.clk, .reset_n,
		.cmd_valid, .cmd_addr, .cmd_bank, .cmd_cs_n, .cmd_ras_n,
		.cmd_cas_n, .cmd_we_n, .cmd_cke, .cmd_odt,
		.cmd_credit,
		.mem_addr, .mem_bank, .mem_cs_n, .mem_ras_n,
		.mem_cas_n, .mem_we_n, .mem_cke, .mem_odt
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_with(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	// every pushed command carries cs_n low so the pins can mark it
	task automatic push_random();
		cmd_valid = 1'b1;
		cmd_addr = mem_addr_t'($random(seed));
		cmd_bank = mem_bank_t'($random(seed));
		cmd_cs_n = 1'b0;
		cmd_ras_n = 1'($random(seed));
		cmd_cas_n = 1'($random(seed));
		cmd_we_n = 1'($random(seed));
		cmd_cke = 1'($random(seed));
		cmd_odt = 1'($random(seed));
		exp_queue.push_back({cmd_addr, cmd_bank, cmd_cs_n, cmd_ras_n, cmd_cas_n,
			cmd_we_n, cmd_cke, cmd_odt});
	endtask

	// mode 0 is idle, 1 is random traffic, 2 holds valid high while credits last
	task automatic drive_cycles(input int cycles, input int mode);
		logic want;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			credits = credits + int'(cmd_credit);
			credit_total = credit_total + int'(cmd_credit);
			if (credits > QUEUE_DEPTH) begin
				fail_with("client credit count rose above the queue depth");
			end
			want = (mode == 2) || (mode == 1 && ($random(seed) & 1) == 1);
			if (want && credits > 0) begin
				push_random();
				credits = credits - 1;
			end else begin
				cmd_valid = 1'b0;
			end
		end
	endtask

	task automatic sample_pins();
		cmd_entry_t exp_cmd;
		if (!reset_n) begin
			check_value("reset addr", 32'd0, 32'(mem_addr));
			check_value("reset bank", 32'd0, 32'(mem_bank));
			check_value("reset cs_n", 32'd1, 32'(mem_cs_n));
			check_value("reset ras_n", 32'd1, 32'(mem_ras_n));
			check_value("reset cas_n", 32'd1, 32'(mem_cas_n));
			check_value("reset we_n", 32'd1, 32'(mem_we_n));
			check_value("reset cke", 32'd0, 32'(mem_cke));
			check_value("reset odt", 32'd0, 32'(mem_odt));
			check_value("reset credit", 32'd0, 32'(cmd_credit));
		end else if (!mem_cs_n) begin
			if (exp_queue.size() == 0) begin
				fail_with("a command reached the pins but none was pending");
			end else begin
				exp_cmd = exp_queue.pop_front();
				check_value($sformatf("cmd %0d pins", seen_count), 32'(exp_cmd),
					32'({mem_addr, mem_bank, mem_cs_n, mem_ras_n, mem_cas_n,
					mem_we_n, mem_cke, mem_odt}));
				last_cke = exp_cmd[1];
				last_odt = exp_cmd[0];
				seen_count++;
			end
		end else begin
			// NOP slot: strobes idle, cke and odt follow the last command
			check_value("idle ras_n", 32'd1, 32'(mem_ras_n));
			check_value("idle cas_n", 32'd1, 32'(mem_cas_n));
			check_value("idle we_n", 32'd1, 32'(mem_we_n));
			check_value("idle cke", 32'(last_cke), 32'(mem_cke));
			check_value("idle odt", 32'(last_odt), 32'(mem_odt));
		end
	endtask

	// pins are stable 1 ns after either clock edge
	always @(clk) begin
		#1;
		sample_pins();
	end

	initial begin
		int wait_cycles;
		clk = 1'b0;
		reset_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_addr = '0;
		cmd_bank = '0;
		cmd_cs_n = 1'b1;
		cmd_ras_n = 1'b1;
		cmd_cas_n = 1'b1;
		cmd_we_n = 1'b1;
		cmd_cke = 1'b0;
		cmd_odt = 1'b0;
		credits = QUEUE_DEPTH;
		credit_total = 0;
		seen_count = 0;
		last_cke = 1'b0;
		last_odt = 1'b0;

		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		@(posedge clk);
		#2;
		check_value("credit after reset", 32'd0, 32'(cmd_credit));

		drive_cycles(300, 1);
		drive_cycles(150, 2);
		drive_cycles(40, 0);
		drive_cycles(100, 2);
		drive_cycles(60, 1);
		drive_cycles(40, 0);

		// drain until every command has reached the pins
		wait_cycles = 0;
		while (exp_queue.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
			drive_cycles(1, 0);
			wait_cycles++;
		end
		if (exp_queue.size() != 0) begin
			fail_with("timed out waiting for the queue to drain");
		end
		// the last pops return their credits a cycle after they leave the queue
		drive_cycles(4, 0);

		check_value("credit total", 32'(seen_count), 32'(credit_total));
		check_value("final credits", 32'(QUEUE_DEPTH), 32'(credits));
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== verilog/addr_cmd_datapath.sv ====
// address/command datapath
// splits the AFI word into DDIO inputs, delaying the high slot by one clk
`timescale 1ns/1ps

module addr_cmd_datapath import ddr2_cmd_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  afi_addr_t afi_address,
	input  afi_bank_t afi_bank,
	input  afi_ctl_t  afi_cs_n,
	input  afi_ctl_t  afi_ras_n,
	input  afi_ctl_t  afi_cas_n,
	input  afi_ctl_t  afi_we_n,
	input  afi_ctl_t  afi_cke,
	input  afi_ctl_t  afi_odt,
	output mem_addr_t ddio_addr_h,
	output mem_addr_t ddio_addr_l,
	output mem_bank_t ddio_bank_h,
	output mem_bank_t ddio_bank_l,
	output logic      ddio_cs_n_h,
	output logic      ddio_cs_n_l,
	output logic      ddio_ras_n_h,
	output logic      ddio_ras_n_l,
	output logic      ddio_cas_n_h,
	output logic      ddio_cas_n_l,
	output logic      ddio_we_n_h,
	output logic      ddio_we_n_l,
	output logic      ddio_cke_h,
	output logic      ddio_cke_l,
	output logic      ddio_odt_h,
	output logic      ddio_odt_l
);

	// slot 0 goes out on the rising edge straight from the AFI register
	assign ddio_addr_h = afi_address[MEM_ADDR_W-1:0];
	assign ddio_bank_h = afi_bank[MEM_BANK_W-1:0];
	assign ddio_cs_n_h = afi_cs_n[0];
	assign ddio_ras_n_h = afi_ras_n[0];
	assign ddio_cas_n_h = afi_cas_n[0];
	assign ddio_we_n_h = afi_we_n[0];
	assign ddio_cke_h = afi_cke[0];
	assign ddio_odt_h = afi_odt[0];

	// slot 1 is held a cycle so the falling-edge capture sees it after slot 0
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ddio_addr_l <= '0;
			ddio_bank_l <= '0;
			ddio_cs_n_l <= NOP_CS_N;
			ddio_ras_n_l <= NOP_RAS_N;
			ddio_cas_n_l <= NOP_CAS_N;
			ddio_we_n_l <= NOP_WE_N;
			ddio_cke_l <= RESET_CKE;
			ddio_odt_l <= RESET_ODT;
		end else begin
			ddio_addr_l <= afi_address[2*MEM_ADDR_W-1:MEM_ADDR_W];
			ddio_bank_l <= afi_bank[2*MEM_BANK_W-1:MEM_BANK_W];
			ddio_cs_n_l <= afi_cs_n[1];
			ddio_ras_n_l <= afi_ras_n[1];
			ddio_cas_n_l <= afi_cas_n[1];
			ddio_we_n_l <= afi_we_n[1];
			ddio_cke_l <= afi_cke[1];
			ddio_odt_l <= afi_odt[1];
		end
	end

endmodule

// ==== verilog/cmd_queue.sv ====
// DDR2 command queue
// circular buffer with two read heads, up to two pops per cycle and credit return
`timescale 1ns/1ps

module cmd_queue import ddr2_cmd_pkg::*; (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         cmd_valid,
	input  mem_addr_t    cmd_addr,
	input  mem_bank_t    cmd_bank,
	input  logic         cmd_cs_n,
	input  logic         cmd_ras_n,
	input  logic         cmd_cas_n,
	input  logic         cmd_we_n,
	input  logic         cmd_cke,
	input  logic         cmd_odt,
	input  credit_t      pop,
	output mem_addr_t    head0_addr,
	output mem_bank_t    head0_bank,
	output logic         head0_cs_n,
	output logic         head0_ras_n,
	output logic         head0_cas_n,
	output logic         head0_we_n,
	output logic         head0_cke,
	output logic         head0_odt,
	output mem_addr_t    head1_addr,
	output mem_bank_t    head1_bank,
	output logic         head1_cs_n,
	output logic         head1_ras_n,
	output logic         head1_cas_n,
	output logic         head1_we_n,
	output logic         head1_cke,
	output logic         head1_odt,
	output queue_count_t occupancy,
	output credit_t      cmd_credit
);

	cmd_entry_t   entries [QUEUE_DEPTH];
	queue_ptr_t   wr_ptr;
	queue_ptr_t   rd_ptr;
	queue_ptr_t   rd_ptr_next;
	queue_count_t count;

	// depth is a power of two so the pointers wrap on their own
	assign rd_ptr_next = rd_ptr + queue_ptr_t'(1);

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			entries[wr_ptr] <= {cmd_addr, cmd_bank, cmd_cs_n, cmd_ras_n,
				cmd_cas_n, cmd_we_n, cmd_cke, cmd_odt};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cmd_credit <= '0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= wr_ptr + queue_ptr_t'(1);
			end
			rd_ptr <= rd_ptr + queue_ptr_t'(pop);
			count <= count + queue_count_t'(cmd_valid) - queue_count_t'(pop);
			// entries freed this cycle go back to the client next cycle
			cmd_credit <= pop;
		end
	end

	// the two oldest entries, head1 is only meaningful with two or more queued
	assign {head0_addr, head0_bank, head0_cs_n, head0_ras_n, head0_cas_n,
		head0_we_n, head0_cke, head0_odt} = entries[rd_ptr];
	assign {head1_addr, head1_bank, head1_cs_n, head1_ras_n, head1_cas_n,
		head1_we_n, head1_cke, head1_odt} = entries[rd_ptr_next];

	assign occupancy = count;

endmodule

// ==== verilog/ddio_cmd_out.sv ====
// DDIO output stage for the address and command pins
// rising edge captures h, falling edge captures l, clk picks which one drives
`timescale 1ns/1ps

module ddio_cmd_out import ddr2_cmd_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  mem_addr_t ddio_addr_h,
	input  mem_addr_t ddio_addr_l,
	input  mem_bank_t ddio_bank_h,
	input  mem_bank_t ddio_bank_l,
	input  logic      ddio_cs_n_h,
	input  logic      ddio_cs_n_l,
	input  logic      ddio_ras_n_h,
	input  logic      ddio_ras_n_l,
	input  logic      ddio_cas_n_h,
	input  logic      ddio_cas_n_l,
	input  logic      ddio_we_n_h,
	input  logic      ddio_we_n_l,
	input  logic      ddio_cke_h,
	input  logic      ddio_cke_l,
	input  logic      ddio_odt_h,
	input  logic      ddio_odt_l,
	output mem_addr_t mem_addr,
	output mem_bank_t mem_bank,
	output logic      mem_cs_n,
	output logic      mem_ras_n,
	output logic      mem_cas_n,
	output logic      mem_we_n,
	output logic      mem_cke,
	output logic      mem_odt
);

	// {addr, bank, cs_n, ras_n, cas_n, we_n, cke, odt}
	cmd_entry_t cap_h;
	cmd_entry_t cap_l;

	// both captures come out of reset as a NOP
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cap_h <= {mem_addr_t'(0), mem_bank_t'(0), NOP_CS_N, NOP_RAS_N,
				NOP_CAS_N, NOP_WE_N, RESET_CKE, RESET_ODT};
		end else begin
			cap_h <= {ddio_addr_h, ddio_bank_h, ddio_cs_n_h, ddio_ras_n_h,
				ddio_cas_n_h, ddio_we_n_h, ddio_cke_h, ddio_odt_h};
		end
	end

	always_ff @(negedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cap_l <= {mem_addr_t'(0), mem_bank_t'(0), NOP_CS_N, NOP_RAS_N,
				NOP_CAS_N, NOP_WE_N, RESET_CKE, RESET_ODT};
		end else begin
			cap_l <= {ddio_addr_l, ddio_bank_l, ddio_cs_n_l, ddio_ras_n_l,
				ddio_cas_n_l, ddio_we_n_l, ddio_cke_l, ddio_odt_l};
		end
	end

	// high phase shows the rising capture, low phase the falling one
	assign {mem_addr, mem_bank, mem_cs_n, mem_ras_n, mem_cas_n, mem_we_n,
		mem_cke, mem_odt} = clk ? cap_h : cap_l;

endmodule

// ==== verilog/ddr2_addr_cmd_top.sv ====
// DDR2 half-rate address/command path top
// queue, packer, datapath and DDIO stage from client commands to memory pins
`timescale 1ns/1ps

module ddr2_addr_cmd_top import ddr2_cmd_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      cmd_valid,
	input  mem_addr_t cmd_addr,
	input  mem_bank_t cmd_bank,
	input  logic      cmd_cs_n,
	input  logic      cmd_ras_n,
	input  logic      cmd_cas_n,
	input  logic      cmd_we_n,
	input  logic      cmd_cke,
	input  logic      cmd_odt,
	output credit_t   cmd_credit,
	output mem_addr_t mem_addr,
	output mem_bank_t mem_bank,
	output logic      mem_cs_n,
	output logic      mem_ras_n,
	output logic      mem_cas_n,
	output logic      mem_we_n,
	output logic      mem_cke,
	output logic      mem_odt
);

	mem_addr_t    head0_addr, head1_addr;
	mem_bank_t    head0_bank, head1_bank;
	logic         head0_cs_n, head0_ras_n, head0_cas_n, head0_we_n, head0_cke, head0_odt;
	logic         head1_cs_n, head1_ras_n, head1_cas_n, head1_we_n, head1_cke, head1_odt;
	queue_count_t occupancy;
	credit_t      pop;

	afi_addr_t afi_address;
	afi_bank_t afi_bank;
	afi_ctl_t  afi_cs_n, afi_ras_n, afi_cas_n, afi_we_n, afi_cke, afi_odt;

	mem_addr_t ddio_addr_h, ddio_addr_l;
	mem_bank_t ddio_bank_h, ddio_bank_l;
	logic      ddio_cs_n_h, ddio_cs_n_l, ddio_ras_n_h, ddio_ras_n_l;
	logic      ddio_cas_n_h, ddio_cas_n_l, ddio_we_n_h, ddio_we_n_l;
	logic      ddio_cke_h, ddio_cke_l, ddio_odt_h, ddio_odt_l;

	cmd_queue cmd_queue_inst (
		.clk, .reset_n,
		.cmd_valid, .cmd_addr, .cmd_bank, .cmd_cs_n, .cmd_ras_n,
		.cmd_cas_n, .cmd_we_n, .cmd_cke, .cmd_odt,
		.pop,
		.head0_addr, .head0_bank, .head0_cs_n, .head0_ras_n,
		.head0_cas_n, .head0_we_n, .head0_cke, .head0_odt,
		.head1_addr, .head1_bank, .head1_cs_n, .head1_ras_n,
		.head1_cas_n, .head1_we_n, .head1_cke, .head1_odt,
		.occupancy, .cmd_credit
	);

	half_rate_cmd_packer half_rate_cmd_packer_inst (
		.clk, .reset_n,
		.head0_addr, .head0_bank, .head0_cs_n, .head0_ras_n,
		.head0_cas_n, .head0_we_n, .head0_cke, .head0_odt,
		.head1_addr, .head1_bank, .head1_cs_n, .head1_ras_n,
		.head1_cas_n, .head1_we_n, .head1_cke, .head1_odt,
		.occupancy, .pop,
		.afi_address, .afi_bank, .afi_cs_n, .afi_ras_n,
		.afi_cas_n, .afi_we_n, .afi_cke, .afi_odt
	);

	addr_cmd_datapath addr_cmd_datapath_inst (
		.clk, .reset_n,
		.afi_address, .afi_bank, .afi_cs_n, .afi_ras_n,
		.afi_cas_n, .afi_we_n, .afi_cke, .afi_odt,
		.ddio_addr_h, .ddio_addr_l, .ddio_bank_h, .ddio_bank_l,
		.ddio_cs_n_h, .ddio_cs_n_l, .ddio_ras_n_h, .ddio_ras_n_l,
		.ddio_cas_n_h, .ddio_cas_n_l, .ddio_we_n_h, .ddio_we_n_l,
		.ddio_cke_h, .ddio_cke_l, .ddio_odt_h, .ddio_odt_l
	);

	ddio_cmd_out ddio_cmd_out_inst (
		.clk, .reset_n,
		.ddio_addr_h, .ddio_addr_l, .ddio_bank_h, .ddio_bank_l,
		.ddio_cs_n_h, .ddio_cs_n_l, .ddio_ras_n_h, .ddio_ras_n_l,
		.ddio_cas_n_h, .ddio_cas_n_l, .ddio_we_n_h, .ddio_we_n_l,
		.ddio_cke_h, .ddio_cke_l, .ddio_odt_h, .ddio_odt_l,
		.mem_addr, .mem_bank, .mem_cs_n, .mem_ras_n,
		.mem_cas_n, .mem_we_n, .mem_cke, .mem_odt
	);

endmodule

// ==== verilog/ddr2_cmd_pkg.sv ====
// DDR2 address/command path shared definitions
// widths, queue sizing and the NOP encoding used by every stage
package ddr2_cmd_pkg;

	// one memory configuration, one rank
	localparam int MEM_ADDR_W = 13;
	localparam int MEM_BANK_W = 3;

	// queue depth doubles as the client's initial credit count
	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_COUNT_W = $clog2(QUEUE_DEPTH + 1);

	// address, bank and the six 1-bit command signals
	localparam int CMD_ENTRY_W = MEM_ADDR_W + MEM_BANK_W + 6;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [MEM_BANK_W-1:0] mem_bank_t;
	typedef logic [2*MEM_ADDR_W-1:0] afi_addr_t;
	typedef logic [2*MEM_BANK_W-1:0] afi_bank_t;
	typedef logic [1:0] afi_ctl_t;
	typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
	typedef logic [QUEUE_COUNT_W-1:0] queue_count_t;
	typedef logic [CMD_ENTRY_W-1:0] cmd_entry_t;
	typedef logic [1:0] credit_t;

	// an idle slot keeps all command strobes deasserted
	localparam logic NOP_CS_N = 1'b1;
	localparam logic NOP_RAS_N = 1'b1;
	localparam logic NOP_CAS_N = 1'b1;
	localparam logic NOP_WE_N = 1'b1;

	// clock enable and ODT stay low until the first real command
	localparam logic RESET_CKE = 1'b0;
	localparam logic RESET_ODT = 1'b0;

endpackage

// ==== verilog/half_rate_cmd_packer.sv ====
// half-rate command packer
// moves up to two queued commands per clk into a registered two-slot AFI word
`timescale 1ns/1ps

module half_rate_cmd_packer import ddr2_cmd_pkg::*; (
	input  logic         clk,
	input  logic         reset_n,
	input  mem_addr_t    head0_addr,
	input  mem_bank_t    head0_bank,
	input  logic         head0_cs_n,
	input  logic         head0_ras_n,
	input  logic         head0_cas_n,
	input  logic         head0_we_n,
	input  logic         head0_cke,
	input  logic         head0_odt,
	input  mem_addr_t    head1_addr,
	input  mem_bank_t    head1_bank,
	input  logic         head1_cs_n,
	input  logic         head1_ras_n,
	input  logic         head1_cas_n,
	input  logic         head1_we_n,
	input  logic         head1_cke,
	input  logic         head1_odt,
	input  queue_count_t occupancy,
	output credit_t      pop,
	output afi_addr_t    afi_address,
	output afi_bank_t    afi_bank,
	output afi_ctl_t     afi_cs_n,
	output afi_ctl_t     afi_ras_n,
	output afi_ctl_t     afi_cas_n,
	output afi_ctl_t     afi_we_n,
	output afi_ctl_t     afi_cke,
	output afi_ctl_t     afi_odt
);

	mem_addr_t s0_addr, s1_addr;
	mem_bank_t s0_bank, s1_bank;
	logic      s0_cs_n, s0_ras_n, s0_cas_n, s0_we_n, s0_cke, s0_odt;
	logic      s1_cs_n, s1_ras_n, s1_cas_n, s1_we_n, s1_cke, s1_odt;
	logic      held_cke;
	logic      held_odt;

	// never stall: take whatever is there, at most two
	assign pop = (occupancy >= queue_count_t'(2)) ? credit_t'(2) : credit_t'(occupancy);

	always_comb begin
		if (pop != credit_t'(0)) begin
			{s0_addr, s0_bank, s0_cs_n, s0_ras_n, s0_cas_n, s0_we_n, s0_cke, s0_odt} =
				{head0_addr, head0_bank, head0_cs_n, head0_ras_n, head0_cas_n,
				head0_we_n, head0_cke, head0_odt};
		end else begin
			{s0_addr, s0_bank, s0_cs_n, s0_ras_n, s0_cas_n, s0_we_n, s0_cke, s0_odt} =
				{mem_addr_t'(0), mem_bank_t'(0), NOP_CS_N, NOP_RAS_N, NOP_CAS_N,
				NOP_WE_N, held_cke, held_odt};
		end
		// an empty slot 1 follows whatever slot 0 carries for cke and odt
		if (pop == credit_t'(2)) begin
			{s1_addr, s1_bank, s1_cs_n, s1_ras_n, s1_cas_n, s1_we_n, s1_cke, s1_odt} =
				{head1_addr, head1_bank, head1_cs_n, head1_ras_n, head1_cas_n,
				head1_we_n, head1_cke, head1_odt};
		end else begin
			{s1_addr, s1_bank, s1_cs_n, s1_ras_n, s1_cas_n, s1_we_n, s1_cke, s1_odt} =
				{mem_addr_t'(0), mem_bank_t'(0), NOP_CS_N, NOP_RAS_N, NOP_CAS_N,
				NOP_WE_N, s0_cke, s0_odt};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			afi_address <= '0;
			afi_bank <= '0;
			afi_cs_n <= {2{NOP_CS_N}};
			afi_ras_n <= {2{NOP_RAS_N}};
			afi_cas_n <= {2{NOP_CAS_N}};
			afi_we_n <= {2{NOP_WE_N}};
			afi_cke <= {2{RESET_CKE}};
			afi_odt <= {2{RESET_ODT}};
			held_cke <= RESET_CKE;
			held_odt <= RESET_ODT;
		end else begin
			afi_address <= {s1_addr, s0_addr};
			afi_bank <= {s1_bank, s0_bank};
			afi_cs_n <= {s1_cs_n, s0_cs_n};
			afi_ras_n <= {s1_ras_n, s0_ras_n};
			afi_cas_n <= {s1_cas_n, s0_cas_n};
			afi_we_n <= {s1_we_n, s0_we_n};
			afi_cke <= {s1_cke, s0_cke};
			afi_odt <= {s1_odt, s0_odt};
			// slot 1 always carries the latest issued cke and odt
			held_cke <= s1_cke;
			held_odt <= s1_odt;
		end
	end

endmodule
